// ==== common/load_pkg.sv ====
`default_nettype none

package load_pkg;

	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] xlen_t; // operands, addresses, results
	typedef logic [63:0]     word_t; // cache word and memory beat

	// low two bits give the access width and the top bit selects zero-extension
	typedef logic [2:0] mem_size_t;

	typedef logic [5:0] tag_t; // physical destination register

	localparam logic [1:0] SIZE_BYTE = 2'd0;
	localparam logic [1:0] SIZE_HALF = 2'd1;
	localparam logic [1:0] SIZE_WORD = 2'd2;

	typedef struct packed {
		tag_t      dest_tag;
		mem_size_t mem_size;
		logic      valid;
	} load_packet_t;

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,   // array output of the registered address is checked
		MISS_REQ, // first beats of the requested line may arrive
		REFILL,
		REREAD    // complete line is read back from storage
	} dcache_state_e;

endpackage

`default_nettype wire

// ==== load_unit/load_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_unit (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  start,
	input  load_pkg::xlen_t       opa,
	input  load_pkg::xlen_t       opb,
	input  load_pkg::load_packet_t packet_in,
	input  load_pkg::word_t       cache_data,
	input  logic                  cache_done,
	output logic                  cache_req,
	output load_pkg::xlen_t       cache_addr,
	output load_pkg::xlen_t       result,
	output load_pkg::load_packet_t packet_out,
	output logic                  busy,
	output logic                  done
);
	import load_pkg::*;

	load_packet_t packet_q;    // packet of the load in flight
	logic [2:0]   offset_q;    // byte offset inside the 64-bit word
	word_t        shifted;     // addressed field moved down to bit 0
	logic [1:0]   size_code;
	logic         is_unsigned;

	assign cache_addr = opa + opb;
	assign cache_req  = start && !busy; // a start while busy is dropped
	assign done       = cache_done;
	assign packet_out = packet_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
		end else if (cache_req) begin
			busy <= 1'b1;
		end else if (cache_done) begin
			busy <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (cache_req) begin
			packet_q <= packet_in;
			offset_q <= cache_addr[2:0];
		end
	end

	assign shifted     = cache_data >> {offset_q, 3'b000};
	assign size_code   = packet_q.mem_size[1:0];
	assign is_unsigned = packet_q.mem_size[2];

	// extension follows the size latched at start
	always_comb begin
		case (size_code)
			SIZE_BYTE: begin
				result = {{(XLEN-8){!is_unsigned && shifted[7]}}, shifted[7:0]};
			end
			SIZE_HALF: begin
				result = {{(XLEN-16){!is_unsigned && shifted[15]}}, shifted[15:0]};
			end
			SIZE_WORD: begin
				result = shifted[XLEN-1:0]; // full width needs no extension
			end
			default: begin
				result = '0; // doubleword loads are not handled here
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== dcache/dcache_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_array #(
	parameter int NUM_SETS   = 16,
	parameter int LINE_BEATS = 4
) (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          read_en,
	input  load_pkg::xlen_t               read_addr,
	input  logic                          fill_en,
	input  logic [$clog2(LINE_BEATS)-1:0] fill_beat,
	input  load_pkg::word_t               fill_data,
	input  logic                          fill_last,
	output logic                          hit,
	output load_pkg::word_t               read_data
);
	import load_pkg::*;

	localparam int OFF_W    = $clog2(LINE_BEATS);
	localparam int INDEX_W  = $clog2(NUM_SETS);
	localparam int LINE_LSB = 3 + OFF_W;
	localparam int TAG_W    = XLEN - LINE_LSB - INDEX_W;

	logic [TAG_W-1:0] tag_mem  [NUM_SETS];
	word_t            data_mem [NUM_SETS][LINE_BEATS];
	logic [NUM_SETS-1:0] valid_q;

	// registered lookup address and target set of a refill
	logic [TAG_W-1:0]   tag_q;
	logic [INDEX_W-1:0] index_q;
	logic [OFF_W-1:0]   word_q;

	always_ff @(posedge clock) begin
		if (read_en) begin
			{tag_q, index_q, word_q} <= read_addr[XLEN-1:3];
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q <= '0;
		end else if (fill_en && fill_last) begin
			valid_q[index_q] <= 1'b1;
		end
	end

	// the slot ahead of the counter may take a stray word between beats;
	// the real beat lands there before the line is marked valid
	always_ff @(posedge clock) begin
		if (fill_en) begin
			data_mem[index_q][fill_beat] <= fill_data;
		end
		if (fill_en && fill_last) begin
			tag_mem[index_q] <= tag_q; // old line in this set is gone
		end
	end

	assign hit       = valid_q[index_q] && (tag_mem[index_q] == tag_q);
	assign read_data = data_mem[index_q][word_q];

endmodule

`default_nettype wire

// ==== dcache/dcache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl #(
	parameter int NUM_SETS   = 16,
	parameter int LINE_BEATS = 4
) (
	input  logic            clock,
	input  logic            reset,
	input  logic            cache_req,
	input  load_pkg::xlen_t cache_addr,
	input  logic            hit,
	input  logic            last_beat,
	output logic            read_en,
	output load_pkg::xlen_t read_addr,
	output logic            fill_en,
	output logic            count_clear,
	output logic            mem_req,
	output load_pkg::xlen_t mem_addr,
	output logic            cache_done
);
	import load_pkg::*;

	localparam int LINE_LSB = 3 + $clog2(LINE_BEATS);
	localparam int INDEX_W  = $clog2(NUM_SETS);
	localparam int TAG_W    = XLEN - LINE_LSB - INDEX_W;

	dcache_state_e state;
	dcache_state_e state_next;

	// the missing line is tracked by tag and set
	logic [TAG_W-1:0]    req_tag;
	logic [INDEX_W-1:0]  req_index;
	logic [LINE_LSB-1:0] req_offset;
	logic                miss;

	always_ff @(posedge clock) begin
		if (state == IDLE && cache_req) begin
			{req_tag, req_index, req_offset} <= cache_addr;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (cache_req) begin
					state_next = LOOKUP;
				end
			end
			LOOKUP:   state_next = hit ? IDLE : MISS_REQ;
			MISS_REQ: state_next = REFILL; // beats may already be arriving
			REFILL: begin
				if (last_beat) begin
					state_next = REREAD;
				end
			end
			REREAD:   state_next = LOOKUP;
			default:  state_next = IDLE;
		endcase
	end

	assign miss = (state == LOOKUP) && !hit;

	// first lookup comes straight from the load unit and the second from the held request
	assign read_en   = (state == IDLE && cache_req) || (state == REREAD);
	assign read_addr = (state == REREAD) ? {req_tag, req_index, req_offset} : cache_addr;

	assign mem_req     = miss;
	assign count_clear = miss; // counter starts from zero in MISS_REQ
	assign mem_addr    = {req_tag, req_index, {LINE_LSB{1'b0}}};
	assign fill_en     = (state == MISS_REQ) || (state == REFILL);
	assign cache_done  = (state == LOOKUP) && hit;

endmodule

`default_nettype wire

// ==== dcache/refill_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module refill_counter #(
	parameter int LINE_BEATS = 4
) (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          clear,
	input  logic                          beat_valid,
	output logic [$clog2(LINE_BEATS)-1:0] beat,
	output logic                          last_beat
);

	always_ff @(posedge clock) begin
		if (reset || clear) begin
			beat <= '0;
		end else if (beat_valid) begin
			beat <= beat + 1'b1; // wraps to zero after the final beat
		end
	end

	assign last_beat = beat_valid && (beat == $clog2(LINE_BEATS)'(LINE_BEATS - 1));

endmodule

`default_nettype wire

// ==== src/load_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_subsystem #(
	parameter int NUM_SETS   = 16,
	parameter int LINE_BEATS = 4
) (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   start,
	input  load_pkg::xlen_t        opa,
	input  load_pkg::xlen_t        opb,
	input  load_pkg::load_packet_t packet_in,
	output load_pkg::xlen_t        result,
	output load_pkg::load_packet_t packet_out,
	output logic                   done,
	output logic                   busy,
	output logic                   mem_req,
	output load_pkg::xlen_t        mem_addr,
	input  load_pkg::word_t        mem_data,
	input  logic                   mem_data_valid
);
	import load_pkg::*;

	logic  cache_req;
	xlen_t cache_addr;
	logic  cache_done;
	word_t read_data;
	logic  hit;
	logic  read_en;
	xlen_t read_addr;
	logic  fill_en;
	logic  count_clear;
	logic  last_beat;
	logic [$clog2(LINE_BEATS)-1:0] beat;

	load_unit u_load_unit (
		.clock      (clock),
		.reset      (reset),
		.start      (start),
		.opa        (opa),
		.opb        (opb),
		.packet_in  (packet_in),
		.cache_data (read_data),
		.cache_done (cache_done),
		.cache_req  (cache_req),
		.cache_addr (cache_addr),
		.result     (result),
		.packet_out (packet_out),
		.busy       (busy),
		.done       (done)
	);

	dcache_ctrl #(
		.NUM_SETS   (NUM_SETS),
		.LINE_BEATS (LINE_BEATS)
	) u_dcache_ctrl (
		.clock       (clock),
		.reset       (reset),
		.cache_req   (cache_req),
		.cache_addr  (cache_addr),
		.hit         (hit),
		.last_beat   (last_beat),
		.read_en     (read_en),
		.read_addr   (read_addr),
		.fill_en     (fill_en),
		.count_clear (count_clear),
		.mem_req     (mem_req),
		.mem_addr    (mem_addr),
		.cache_done  (cache_done)
	);

	refill_counter #(
		.LINE_BEATS (LINE_BEATS)
	) u_refill_counter (
		.clock      (clock),
		.reset      (reset),
		.clear      (count_clear),
		.beat_valid (mem_data_valid),
		.beat       (beat),
		.last_beat  (last_beat)
	);

	dcache_array #(
		.NUM_SETS   (NUM_SETS),
		.LINE_BEATS (LINE_BEATS)
	) u_dcache_array (
		.clock     (clock),
		.reset     (reset),
		.read_en   (read_en),
		.read_addr (read_addr),
		.fill_en   (fill_en),
		.fill_beat (beat),
		.fill_data (mem_data),
		.fill_last (last_beat),
		.hit       (hit),
		.read_data (read_data)
	);

endmodule

`default_nettype wire

// ==== verification/tb_load_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_load_subsystem;
	import load_pkg::*;

	localparam int NUM_SETS       = 16;
	localparam int LINE_BEATS     = 4;
	localparam int LINE_LSB       = 3 + $clog2(LINE_BEATS);
	localparam int INDEX_W        = $clog2(NUM_SETS);
	localparam int RESET_CYCLES   = 10;
	localparam int NUM_LOADS      = 300;
	localparam int DIRECTED_LOADS = 32;
	localparam int TIMEOUT_CYCLES = NUM_LOADS * 60 + RESET_CYCLES;

	logic         clock;
	logic         reset;
	logic         start;
	xlen_t        opa;
	xlen_t        opb;
	load_packet_t packet_in;
	xlen_t        result;
	load_packet_t packet_out;
	logic         done;
	logic         busy;
	logic         mem_req;
	xlen_t        mem_addr;
	word_t        mem_data;
	logic         mem_data_valid;

	logic [31:0] rng;
	int          cycle;
	int          final_beat_cycle; // cycle of the last refill beat or -1 before it
	logic [31:0] model_tag [NUM_SETS];
	logic        model_valid [NUM_SETS];
	int          last_tag_sel;
	int          last_index;

	load_subsystem #(
		.NUM_SETS   (NUM_SETS),
		.LINE_BEATS (LINE_BEATS)
	) UUT (
		.clock          (clock),
		.reset          (reset),
		.start          (start),
		.opa            (opa),
		.opb            (opb),
		.packet_in      (packet_in),
		.result         (result),
		.packet_out     (packet_out),
		.done           (done),
		.busy           (busy),
		.mem_req        (mem_req),
		.mem_addr       (mem_addr),
		.mem_data       (mem_data),
		.mem_data_valid (mem_data_valid)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] v;
		v = x;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	// memory contents depend on the full 64-bit word address
	function automatic word_t mem_word(input xlen_t word_addr);
		logic [31:0] lo;
		logic [31:0] hi;
		lo = xorshift32(word_addr ^ 32'h5a5a_1234);
		hi = xorshift32(lo ^ word_addr ^ 32'h0f1e_2d3c);
		return {hi, lo};
	endfunction

	function automatic xlen_t expected_load(input word_t data, input logic [2:0] offset,
			input mem_size_t size);
		word_t field;
		logic  zero_ext;
		field    = data >> (8 * offset);
		zero_ext = size[2];
		case (size[1:0])
			2'd0:    return zero_ext ? 32'(field[7:0]) : 32'($signed(field[7:0]));
			2'd1:    return zero_ext ? 32'(field[15:0]) : 32'($signed(field[15:0]));
			default: return field[31:0];
		endcase
	endfunction

	function automatic xlen_t make_addr(input int tag_sel, input int index, input int word,
			input int byte_off);
		xlen_t tag_bits;
		tag_bits = 32'h0009_e3b5 * tag_sel + 32'h0000_0011; // a few distinct tags
		return (tag_bits << (LINE_LSB + INDEX_W)) | (xlen_t'(index) << LINE_LSB)
			| (xlen_t'(word) << 3) | xlen_t'(byte_off);
	endfunction

	task automatic report_fail(input string what);
		$display("%s", what);
		$display("Test FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] expected);
		assert (got === expected) else begin
			report_fail($sformatf("mismatch at %0t: %s is %h, expected %h",
				$time, name, got, expected));
		end
	endtask

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle <= cycle + 1;
		assert (cycle < TIMEOUT_CYCLES) else begin
			report_fail("timeout: the loads did not finish within the cycle limit");
		end
	end

	// memory side answers each request with LINE_BEATS beats
	initial begin
		xlen_t line;
		int    gap;
		mem_data       = '0;
		mem_data_valid = 1'b0;
		forever begin
			@(negedge clock);
			if (mem_req === 1'b1) begin
				line = mem_addr;
				for (int b = 0; b < LINE_BEATS; b++) begin
					rng = xorshift32(rng);
					gap = rng % 6;
					repeat (gap) begin
						@(posedge clock);
						#1;
						mem_data_valid = 1'b0;
						mem_data       = {rng, rng ^ 32'hffff_0000}; // noise between beats
					end
					@(posedge clock);
					#1;
					mem_data_valid   = 1'b1;
					mem_data         = mem_word((line >> 3) + b);
					final_beat_cycle = cycle;
				end
				@(posedge clock);
				#1;
				mem_data_valid = 1'b0;
			end
		end
	end

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clock);
			#1;
			@(negedge clock);
			check_value("busy", busy, 0);
			check_value("done", done, 0);
			check_value("mem_req", mem_req, 0);
		end
	endtask

	task automatic run_load(input xlen_t addr, input mem_size_t size, input tag_t dest_tag);
		xlen_t        opb_val;
		load_packet_t pkt;
		logic         expect_miss;
		int           start_cycle;
		int           index;
		logic [31:0]  line_tag;
		xlen_t        expected;
		logic         saw_done;
		index       = (addr >> LINE_LSB) % NUM_SETS;
		line_tag    = addr >> (LINE_LSB + INDEX_W);
		expect_miss = !(model_valid[index] && model_tag[index] == line_tag);
		expected    = expected_load(mem_word(addr >> 3), addr[2:0], size);
		rng         = xorshift32(rng);
		opb_val     = rng;
		pkt.dest_tag = dest_tag;
		pkt.mem_size = size;
		pkt.valid    = 1'b1;
		final_beat_cycle = -1;

		@(posedge clock);
		#1;
		start       = 1'b1;
		opa         = addr - opb_val;
		opb         = opb_val;
		packet_in   = pkt;
		start_cycle = cycle;
		@(negedge clock);
		check_value("busy", busy, 0);
		check_value("done", done, 0);
		check_value("mem_req", mem_req, 0);

		@(posedge clock);
		#1;
		rng       = xorshift32(rng);
		start     = 1'b0;
		opa       = rng; // operands and packet change once start is gone
		opb       = ~rng;
		packet_in = ~pkt;

		saw_done = 1'b0;
		while (!saw_done) begin
			@(negedge clock);
			check_value("busy", busy, 1);
			if (cycle == start_cycle + 1) begin
				check_value("mem_req", mem_req, expect_miss);
			end else begin
				check_value("mem_req", mem_req, 0);
			end
			if (mem_req) begin
				check_value("mem_addr", mem_addr, addr & ~((32'd1 << LINE_LSB) - 1));
			end
			if (done) begin
				saw_done = 1'b1;
				if (expect_miss) begin
					assert (final_beat_cycle >= 0 && cycle == final_beat_cycle + 2) else begin
						report_fail($sformatf(
							"done at cycle %0d is not two cycles after the last beat (%0d)",
							cycle, final_beat_cycle));
					end
				end else begin
					assert (cycle == start_cycle + 1) else begin
						report_fail("done on a hit did not come one cycle after start");
					end
				end
				check_value("result", result, expected);
				check_value("packet_out", packet_out, pkt);
			end
		end

		if (expect_miss) begin
			model_valid[index] = 1'b1;
			model_tag[index]   = line_tag; // the refill evicts the old line
		end
	endtask

	task automatic random_load();
		int        tag_sel;
		int        index;
		int        word;
		int        byte_off;
		int        code;
		logic      zero_ext;
		xlen_t     addr;
		mem_size_t size;
		rng = xorshift32(rng);
		if (rng[0]) begin
			tag_sel = last_tag_sel; // stay in the last line for hits
			index   = last_index;
		end else begin
			tag_sel = rng[9:8];
			index   = rng[23:16] % NUM_SETS;
		end
		rng      = xorshift32(rng);
		word     = rng[7:0] % LINE_BEATS;
		code     = rng[15:8] % 3;
		zero_ext = rng[16];
		byte_off = rng[26:24] & ~((1 << code) - 1); // aligned to the access size
		size     = {zero_ext, code[1:0]};
		addr     = make_addr(tag_sel, index, word, byte_off);
		rng      = xorshift32(rng);
		run_load(addr, size, rng[5:0]);
		last_tag_sel = tag_sel;
		last_index   = index;
		rng = xorshift32(rng);
		idle_cycles(rng % 3);
	endtask

	initial begin
		rng       = 32'he747f39c;
		reset     = 1'b1;
		start     = 1'b0;
		opa       = '0;
		opb       = '0;
		packet_in = '0;
		final_beat_cycle = -1;
		for (int i = 0; i < NUM_SETS; i++) begin
			model_valid[i] = 1'b0;
			model_tag[i]   = '0;
		end

		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		reset = 1'b0;
		idle_cycles(5);

		// line A misses, hits, is evicted by B in the same set and misses again
		run_load(make_addr(0, 3, 1, 4), 3'b010, 6'd1);
		run_load(make_addr(0, 3, 3, 6), 3'b101, 6'd2);
		run_load(make_addr(1, 3, 0, 1), 3'b000, 6'd3);
		run_load(make_addr(0, 3, 1, 4), 3'b100, 6'd4);
		last_tag_sel = 0;
		last_index   = 3;

		// every size and offset in one resident word
		for (int zx = 0; zx < 2; zx++) begin
			for (int code = 0; code < 3; code++) begin
				for (int off = 0; off < 8; off += (1 << code)) begin
					rng = xorshift32(rng);
					run_load(make_addr(0, 3, 2, off), {zx[0], code[1:0]}, rng[5:0]);
				end
			end
		end

		for (int n = 0; n < NUM_LOADS - DIRECTED_LOADS; n++) begin
			random_load();
		end

		idle_cycles(2);
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
common/load_pkg.sv
load_unit/load_unit.sv
dcache/dcache_array.sv
dcache/dcache_ctrl.sv
dcache/refill_counter.sv
src/load_subsystem.sv
verification/tb_load_subsystem.sv
